// ==== flist.f ====
verilog/pe_ctrl_pkg.sv
verilog/qsim_mem_pkg.sv
verilog/dense_gate_sequencer.sv
verilog/state_read_walker.sv
verilog/writeback_tracker.sv
verilog/state_port_arbiter.sv
verilog/pe_controller.sv
bench/pe_controller_sva.sv
bench/pe_controller_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := pe_controller_tb
FLIST     := flist.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# a missing pass line also counts as failure
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "no pass status in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/pe_controller_tb.sv ====
`default_nettype none

module pe_controller_tb
	import pe_ctrl_pkg::*, qsim_mem_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_RUNS    = 10;
	localparam int MAX_EXE     = 32;
	// worst run is about E plus fetch, ALU tail and done
	localparam int TIMEOUT_CYC = NUM_RUNS * (MAX_EXE + 20);

	logic              clk;
	logic              rst_n;
	logic              i_start_valid;
	qbit_t             i_qbit_num;
	state_addr_t       i_exe_num;
	gate_word_t  [1:0] i_gate_data = '0;
	logic              o_start_ready;
	logic        [1:0] o_gate_en;
	gate_addr_t  [1:0] o_gate_addr;
	logic        [1:0] o_state_en;
	logic        [1:0] o_state_we;
	state_addr_t [1:0] o_state_addr;
	logic              o_alu_start;
	logic              o_coef_valid;
	logic              o_remote_pair;
	logic              o_done;

	logic [31:0] lfsr = 32'h3d51_74bf;
	qbit_t       cur_pos = '0;
	int          exp_half = 0;
	logic        exp_remote = 1'b0;
	// {lo, hi} pairs still to be read and pairs awaiting write-back
	logic [31:0] rd_exp [$];
	logic [31:0] wb_exp [$];
	int          wb_cyc [$];
	int          cyc = 0;
	int          ld_cnt = 0;
	int          wb_cnt = 0;
	int          last_wb_cyc = 0;
	int          done_cnt = 0;
	int          err_cnt = 0;
	int          chk_cnt = 0;

	pe_controller i_dut (.*);

	always #5 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int width, output int val);
		val = 0;
		repeat (width) begin
			lfsr = lfsr_next(lfsr);
			val = (val << 1) | int'(lfsr[0]);
		end
	endtask

	// coefficient pattern spread over all address bits
	function automatic gate_word_t coef_word(input gate_addr_t a);
		return {8{2'b10, a}};
	endfunction

	task automatic compare_hex(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		chk_cnt++;
		assert (got == exp) else begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		chk_cnt++;
		assert (cond) else begin
			$display("error: %s", what);
			err_cnt++;
		end
	endtask

	task automatic report_counts();
		$display("checks %0d, errors %0d", chk_cnt, err_cnt);
	endtask

	// gate memory with one cycle read latency on both ports
	always @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (o_gate_en[i]) begin
				if (o_gate_addr[i] == GATE_POS_ADDR) begin
					i_gate_data[i] <= gate_word_t'(cur_pos);
				end else begin
					i_gate_data[i] <= coef_word(o_gate_addr[i]);
				end
			end
		end
	end

	// one start with its expected pairs from b = n - p - 1 and a wait for done
	task automatic do_run(input int n, input int e_log, input int p);
		int   exe;
		int   b;
		int   len;
		logic ready_seen;
		exe = 1 << e_log;
		b = n - p - 1;
		len = 1 << b;
		cur_pos = qbit_t'(p);
		exp_half = exe / 2;
		exp_remote = (len >= exe);
		rd_exp.delete();
		for (int k = 0; k < exe; k++) begin
			if (!exp_remote && ((k >> b) & 1) == 0) begin
				rd_exp.push_back({16'(k), 16'(k + len)});
			end else if (exp_remote && (k % 2) == 0) begin
				rd_exp.push_back({16'(k), 16'(k + 1)});
			end
		end
		i_start_valid <= 1'b1;
		i_qbit_num    <= qbit_t'(n);
		i_exe_num     <= state_addr_t'(exe);
		// ready seen mid-cycle means taken at the next edge
		do begin
			@(negedge clk);
			ready_seen = o_start_ready;
			@(posedge clk);
		end while (!ready_seen);
		i_start_valid <= 1'b0;
		do begin
			@(negedge clk);
		end while (!o_done);
		@(posedge clk);
	endtask

	always @(posedge clk) begin
		if (rst_n) begin
			cyc <= cyc + 1;
		end
		if (cyc >= TIMEOUT_CYC) begin
			$display("timeout: runs did not finish within %0d cycles", TIMEOUT_CYC);
			report_counts();
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// outputs sampled mid-cycle
	always @(negedge clk) begin
		logic [31:0] pair;
		int          rd_at;
		if (rst_n) begin
			// descriptor fetch steps after acceptance
			case (ld_cnt)
				1: begin
					compare_hex("o_gate_en", o_gate_en, 32'h1);
					compare_hex("o_gate_addr[0]", o_gate_addr[0], 32'h0);
					compare_hex("o_alu_start", o_alu_start, 32'h1);
				end
				2, 3: begin
					compare_hex("o_gate_en", o_gate_en, 32'h3);
					compare_hex("o_gate_addr[0]", o_gate_addr[0], 2 * ld_cnt - 3);
					compare_hex("o_gate_addr[1]", o_gate_addr[1], 2 * ld_cnt - 2);
				end
				4: begin
					compare_hex("o_coef_valid", o_coef_valid, 32'h1);
					compare_hex("o_gate_en", o_gate_en, 32'h0);
					compare_hex("o_remote_pair", o_remote_pair, exp_remote);
				end
				default: begin
					compare_hex("o_coef_valid", o_coef_valid, 32'h0);
					compare_hex("o_gate_en", o_gate_en, 32'h0);
					compare_hex("o_alu_start", o_alu_start, 32'h0);
				end
			endcase
			ld_cnt = (ld_cnt inside {[1:3]}) ? ld_cnt + 1 : 0;
			if (i_start_valid && o_start_ready) begin
				ld_cnt = 1;
				wb_cnt = 0;
			end
			if (o_state_en == 2'b11 && o_state_we == 2'b00) begin
				expect_true(rd_exp.size() != 0, "state read issued after the last expected pair");
				if (rd_exp.size() != 0) begin
					pair = rd_exp.pop_front();
					compare_hex("o_state_addr[0] read", o_state_addr[0], pair[31:16]);
					compare_hex("o_state_addr[1] read", o_state_addr[1], pair[15:0]);
					compare_hex("o_remote_pair", o_remote_pair, exp_remote);
					wb_exp.push_back(pair);
					wb_cyc.push_back(cyc);
				end
			end else if (o_state_en == 2'b11 && o_state_we == 2'b11) begin
				expect_true(wb_exp.size() != 0, "write-back with no read pair in flight");
				if (wb_exp.size() != 0) begin
					pair = wb_exp.pop_front();
					rd_at = wb_cyc.pop_front();
					compare_hex("o_state_addr[0] write", o_state_addr[0], pair[31:16]);
					compare_hex("o_state_addr[1] write", o_state_addr[1], pair[15:0]);
					compare_hex("write-back latency", cyc - rd_at, ALU_LATENCY);
				end
				wb_cnt++;
				last_wb_cyc = cyc;
			end else begin
				// partial enable would mix a read and a write
				compare_hex("o_state_en", o_state_en, 32'h0);
			end
			if (o_done) begin
				compare_hex("write-back count", wb_cnt, exp_half);
				expect_true(rd_exp.size() == 0, "o_done before every expected pair was read");
				expect_true(last_wb_cyc == cyc - 1, "o_done did not follow the final write-back");
				done_cnt++;
			end
		end
	end

	initial begin
		int v;
		int n;
		int e_log;
		int p;
		clk = 1'b0;
		rst_n = 1'b0;
		i_start_valid = 1'b0;
		i_qbit_num = '0;
		i_exe_num = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		// one local and one remote walk first
		do_run(4, 3, 2);
		do_run(4, 2, 0);
		for (int r = 2; r < NUM_RUNS; r++) begin
			take_bits(3, v);
			e_log = 1 + v % 5;
			take_bits(2, v);
			n = e_log + v;
			take_bits(4, v);
			p = v % n;
			do_run(n, e_log, p);
		end
		compare_hex("done pulse count", done_cnt, NUM_RUNS);
		// protocol assertion failures from the bound checker
		err_cnt += i_dut.i_sva.err_cnt;
		report_counts();
		if (err_cnt == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/pe_controller_sva.sv ====
`default_nettype none

module pe_controller_sva (
	input wire       clk,
	input wire       rst_n,
	input wire       i_start_valid,
	input wire       o_start_ready,
	input wire [1:0] o_state_en,
	input wire [1:0] o_state_we,
	input wire       o_done
);
	timeunit 1ns;
	timeprecision 1ps;

	// high from start acceptance to the done pulse
	logic busy_q;
	// failed assertion count
	int   err_cnt = 0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
		end else if (i_start_valid && o_start_ready) begin
			busy_q <= 1'b1;
		end else if (o_done) begin
			busy_q <= 1'b0;
		end
	end

	// no write on a disabled port
	we_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
		(o_state_we & ~o_state_en) == 2'b00)
		else begin
			err_cnt++;
			$error("state write enable without port enable");
		end

	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		o_done |=> !o_done)
		else begin
			err_cnt++;
			$error("o_done held longer than one cycle");
		end

	ready_low_busy: assert property (@(posedge clk) disable iff (!rst_n)
		busy_q && !o_done |-> !o_start_ready)
		else begin
			err_cnt++;
			$error("o_start_ready high while a run is in progress");
		end

endmodule

bind pe_controller pe_controller_sva i_sva (
	.clk           (clk),
	.rst_n         (rst_n),
	.i_start_valid (i_start_valid),
	.o_start_ready (o_start_ready),
	.o_state_en    (o_state_en),
	.o_state_we    (o_state_we),
	.o_done        (o_done)
);

`default_nettype wire

// ==== verilog/pe_controller.sv ====
`default_nettype none

module pe_controller
	import pe_ctrl_pkg::*, qsim_mem_pkg::*;
(
	input  wire                clk,
	input  wire                rst_n,
	input  wire                i_start_valid,
	input  qbit_t              i_qbit_num,
	input  state_addr_t        i_exe_num,
	input  gate_word_t  [1:0]  i_gate_data,
	output logic               o_start_ready,
	output logic        [1:0]  o_gate_en,
	output gate_addr_t  [1:0]  o_gate_addr,
	output logic        [1:0]  o_state_en,
	output logic        [1:0]  o_state_we,
	output state_addr_t [1:0]  o_state_addr,
	output logic               o_alu_start,
	output logic               o_coef_valid,
	output logic               o_remote_pair,
	output logic               o_done
);

	// sequencer to walker
	logic        walk_go;
	qbit_t       pkg_bits;
	state_addr_t exe_num;

	// walker to arbiter and tracker
	logic        rd_req;
	state_addr_t rd_addr_lo;
	state_addr_t rd_addr_hi;
	logic        walk_last;
	logic        rd_grant;
	logic        rd_fire;

	// tracker to arbiter and sequencer
	logic        wb_req;
	state_addr_t wb_addr_lo;
	state_addr_t wb_addr_hi;
	logic        wb_final;

	dense_gate_sequencer u_seq (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_start_valid (i_start_valid),
		.i_qbit_num    (i_qbit_num),
		.i_exe_num     (i_exe_num),
		.i_gate_data   (i_gate_data),
		.i_wb_final    (wb_final),
		.o_start_ready (o_start_ready),
		.o_gate_en     (o_gate_en),
		.o_gate_addr   (o_gate_addr),
		.o_alu_start   (o_alu_start),
		.o_coef_valid  (o_coef_valid),
		.o_walk_go     (walk_go),
		.o_pkg_bits    (pkg_bits),
		.o_remote      (o_remote_pair),
		.o_exe_num     (exe_num),
		.o_done        (o_done)
	);

	state_read_walker u_walker (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_walk_go    (walk_go),
		.i_pkg_bits   (pkg_bits),
		.i_remote     (o_remote_pair),
		.i_exe_num    (exe_num),
		.i_rd_grant   (rd_grant),
		.o_rd_req     (rd_req),
		.o_rd_addr_lo (rd_addr_lo),
		.o_rd_addr_hi (rd_addr_hi),
		.o_walk_last  (walk_last)
	);

	writeback_tracker u_tracker (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_rd_fire    (rd_fire),
		.i_rd_addr_lo (rd_addr_lo),
		.i_rd_addr_hi (rd_addr_hi),
		.i_walk_last  (walk_last),
		.o_wb_req     (wb_req),
		.o_wb_addr_lo (wb_addr_lo),
		.o_wb_addr_hi (wb_addr_hi),
		.o_wb_final   (wb_final)
	);

	state_port_arbiter u_arb (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_rd_req     (rd_req),
		.i_rd_addr_lo (rd_addr_lo),
		.i_rd_addr_hi (rd_addr_hi),
		.i_wb_req     (wb_req),
		.i_wb_addr_lo (wb_addr_lo),
		.i_wb_addr_hi (wb_addr_hi),
		.o_rd_grant   (rd_grant),
		.o_rd_fire    (rd_fire),
		.o_state_en   (o_state_en),
		.o_state_we   (o_state_we),
		.o_state_addr (o_state_addr)
	);

endmodule

`default_nettype wire

// ==== verilog/state_port_arbiter.sv ====
`default_nettype none

module state_port_arbiter
	import qsim_mem_pkg::*;
(
	input  wire                clk,
	input  wire                rst_n,
	input  wire                i_rd_req,
	input  state_addr_t        i_rd_addr_lo,
	input  state_addr_t        i_rd_addr_hi,
	input  wire                i_wb_req,
	input  state_addr_t        i_wb_addr_lo,
	input  state_addr_t        i_wb_addr_hi,
	output logic               o_rd_grant,
	output logic               o_rd_fire,
	output logic        [1:0]  o_state_en,
	output logic        [1:0]  o_state_we,
	output state_addr_t [1:0]  o_state_addr
);

	// write-backs cannot wait, the ALU result is gone next cycle
	assign o_rd_grant = !i_wb_req;
	assign o_rd_fire  = i_rd_req && o_rd_grant;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_state_en <= 2'b00;
			o_state_we <= 2'b00;
		end else if (i_wb_req) begin
			o_state_en <= 2'b11;
			o_state_we <= 2'b11;
		end else if (o_rd_fire) begin
			o_state_en <= 2'b11;
			o_state_we <= 2'b00;
		end else begin
			o_state_en <= 2'b00;
			o_state_we <= 2'b00;
		end
	end

	// port 0 lower amplitude, port 1 upper
	always_ff @(posedge clk) begin
		if (i_wb_req) begin
			o_state_addr[0] <= i_wb_addr_lo;
			o_state_addr[1] <= i_wb_addr_hi;
		end else if (o_rd_fire) begin
			o_state_addr[0] <= i_rd_addr_lo;
			o_state_addr[1] <= i_rd_addr_hi;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/writeback_tracker.sv ====
`default_nettype none

module writeback_tracker
	import pe_ctrl_pkg::*, qsim_mem_pkg::*;
(
	input  wire         clk,
	input  wire         rst_n,
	input  wire         i_rd_fire,
	input  state_addr_t i_rd_addr_lo,
	input  state_addr_t i_rd_addr_hi,
	input  wire         i_walk_last,
	output logic        o_wb_req,
	output state_addr_t o_wb_addr_lo,
	output state_addr_t o_wb_addr_hi,
	output logic        o_wb_final
);

	// one stage per cycle of ALU latency
	logic [ALU_LATENCY-1:0] vld_q;
	logic [ALU_LATENCY-1:0] last_q;
	state_addr_t            lo_q [ALU_LATENCY];
	state_addr_t            hi_q [ALU_LATENCY];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_q  <= '0;
			last_q <= '0;
		end else begin
			vld_q  <= {vld_q[ALU_LATENCY-2:0], i_rd_fire};
			// last tag only rides on an issued pair
			last_q <= {last_q[ALU_LATENCY-2:0], i_rd_fire && i_walk_last};
		end
	end

	// address pairs follow the valid bits
	always_ff @(posedge clk) begin
		lo_q[0] <= i_rd_addr_lo;
		hi_q[0] <= i_rd_addr_hi;
		for (int i = 1; i < ALU_LATENCY; i++) begin
			lo_q[i] <= lo_q[i-1];
			hi_q[i] <= hi_q[i-1];
		end
	end

	// tail of the line, several pairs may be ahead of it
	assign o_wb_req     = vld_q[ALU_LATENCY-1];
	assign o_wb_addr_lo = lo_q[ALU_LATENCY-1];
	assign o_wb_addr_hi = hi_q[ALU_LATENCY-1];
	assign o_wb_final   = vld_q[ALU_LATENCY-1] && last_q[ALU_LATENCY-1];

endmodule

`default_nettype wire

// ==== verilog/state_read_walker.sv ====
`default_nettype none

module state_read_walker
	import pe_ctrl_pkg::*, qsim_mem_pkg::*;
(
	input  wire         clk,
	input  wire         rst_n,
	input  wire         i_walk_go,
	input  qbit_t       i_pkg_bits,
	input  wire         i_remote,
	input  state_addr_t i_exe_num,
	input  wire         i_rd_grant,
	output logic        o_rd_req,
	output state_addr_t o_rd_addr_lo,
	output state_addr_t o_rd_addr_hi,
	output logic        o_walk_last
);

	logic        active_q;
	state_addr_t base_q;
	state_addr_t ptr_q;
	state_addr_t cnt_q;
	// pair distance, 1 for remote walks
	state_addr_t len_q;
	// pairs to issue, E/2
	state_addr_t half_q;
	logic        fire;
	logic        pkg_end;

	assign o_rd_req     = active_q;
	assign fire         = active_q && i_rd_grant;
	assign o_rd_addr_lo = base_q + ptr_q;
	assign o_rd_addr_hi = o_rd_addr_lo + len_q;
	assign pkg_end      = (ptr_q == len_q - 1'b1);
	assign o_walk_last  = active_q && (cnt_q == half_q - 1'b1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active_q <= 1'b0;
			base_q   <= '0;
			ptr_q    <= '0;
			cnt_q    <= '0;
		end else if (i_walk_go) begin
			active_q <= 1'b1;
			base_q   <= '0;
			ptr_q    <= '0;
			cnt_q    <= '0;
		end else if (fire) begin
			cnt_q <= cnt_q + 1'b1;
			if (o_walk_last) begin
				active_q <= 1'b0;
			end
			// skip the upper half of the package, stride 2L
			if (pkg_end) begin
				ptr_q  <= '0;
				base_q <= base_q + state_addr_t'(len_q << 1);
			end else begin
				ptr_q <= ptr_q + 1'b1;
			end
		end
	end

	// walk shape, fixed for the whole run
	always_ff @(posedge clk) begin
		if (i_walk_go) begin
			len_q  <= i_remote ? state_addr_t'(1) : (state_addr_t'(1) << i_pkg_bits);
			half_q <= i_exe_num >> 1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/dense_gate_sequencer.sv ====
`default_nettype none

module dense_gate_sequencer
	import pe_ctrl_pkg::*, qsim_mem_pkg::*;
(
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     i_start_valid,
	input  qbit_t                   i_qbit_num,
	input  state_addr_t             i_exe_num,
	input  gate_word_t  [1:0]       i_gate_data,
	input  wire                     i_wb_final,
	output logic                    o_start_ready,
	output logic        [1:0]       o_gate_en,
	output gate_addr_t  [1:0]       o_gate_addr,
	output logic                    o_alu_start,
	output logic                    o_coef_valid,
	output logic                    o_walk_go,
	output qbit_t                   o_pkg_bits,
	output logic                    o_remote,
	output state_addr_t             o_exe_num,
	output logic                    o_done
);

	seq_state_t  state_q;
	logic [1:0]  ld_step_q;
	logic        accept;
	qbit_t       qbit_q;
	qbit_t       pos_q;
	qbit_t       pkg_bits_c;
	state_addr_t pkg_len_c;
	logic        remote_c;
	state_addr_t o_exe_num_q;

	assign o_start_ready = (state_q == SEQ_IDLE);
	assign accept        = i_start_valid && o_start_ready;
	assign o_exe_num     = o_exe_num_q;

	// b = n - p - 1 and package length 2^b
	assign pkg_bits_c = qbit_q - pos_q - 1'b1;
	assign pkg_len_c  = state_addr_t'(1) << pkg_bits_c;
	// partner outside the slice once a package covers all of E
	assign remote_c   = (pkg_bits_c >= STATE_ADDR_W) || (pkg_len_c >= o_exe_num_q);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q      <= SEQ_IDLE;
			ld_step_q    <= '0;
			o_gate_en    <= '0;
			o_alu_start  <= 1'b0;
			o_coef_valid <= 1'b0;
			o_walk_go    <= 1'b0;
			o_remote     <= 1'b0;
			o_done       <= 1'b0;
		end else begin
			// single-cycle strobes
			o_alu_start  <= 1'b0;
			o_coef_valid <= 1'b0;
			o_walk_go    <= 1'b0;
			o_done       <= 1'b0;
			case (state_q)
				SEQ_IDLE: begin
					if (accept) begin
						// position word on port 0 only
						state_q     <= SEQ_LOAD;
						ld_step_q   <= '0;
						o_gate_en   <= 2'b01;
						o_alu_start <= 1'b1;
					end
				end
				SEQ_LOAD: begin
					ld_step_q <= ld_step_q + 1'b1;
					if (ld_step_q == 2'd2) begin
						o_gate_en    <= 2'b00;
						o_remote     <= remote_c;
						o_coef_valid <= 1'b1;
						o_walk_go    <= 1'b1;
						state_q      <= SEQ_WALK;
					end else begin
						o_gate_en <= 2'b11;
					end
				end
				SEQ_WALK: begin
					state_q <= SEQ_DRAIN;
				end
				SEQ_DRAIN: begin
					if (i_wb_final) begin
						state_q <= SEQ_DONE;
					end
				end
				default: begin
					o_done  <= 1'b1;
					state_q <= SEQ_IDLE;
				end
			endcase
		end
	end

	// operands, position and gate read addresses
	always_ff @(posedge clk) begin
		if (accept) begin
			qbit_q         <= i_qbit_num;
			o_exe_num_q    <= i_exe_num;
			o_gate_addr[0] <= GATE_POS_ADDR;
			o_gate_addr[1] <= GATE_POS_ADDR;
		end else if (state_q == SEQ_LOAD) begin
			case (ld_step_q)
				2'd0: begin
					o_gate_addr[0] <= GATE_POS_ADDR + gate_addr_t'(1);
					o_gate_addr[1] <= GATE_POS_ADDR + gate_addr_t'(2);
				end
				2'd1: begin
					o_gate_addr[0] <= GATE_POS_ADDR + gate_addr_t'(3);
					o_gate_addr[1] <= GATE_POS_ADDR + gate_addr_t'(4);
					// position word is back from the first read
					pos_q          <= i_gate_data[0][MAX_QBIT_W-1:0];
				end
				default: begin
					o_pkg_bits <= pkg_bits_c;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/qsim_mem_pkg.sv ====
`default_nettype none

package qsim_mem_pkg;

	// local slice of the state vector
	localparam int STATE_ADDR_W = 16;

	// address or amplitude count
	typedef logic [STATE_ADDR_W-1:0] state_addr_t;

	// gate memory
	localparam int GATE_ADDR_W = 6;
	localparam int GATE_WORD_W = 64;

	typedef logic [GATE_ADDR_W-1:0] gate_addr_t;

	// one complex coefficient, re and im halves
	typedef logic [GATE_WORD_W-1:0] gate_word_t;

	// dense descriptor layout
	// position word first, coefficients at +1 .. +4
	localparam gate_addr_t GATE_POS_ADDR = '0;

endpackage

`default_nettype wire

// ==== verilog/pe_ctrl_pkg.sv ====
`default_nettype none

package pe_ctrl_pkg;

	// qubit count and gate position share one width
	localparam int MAX_QBIT_W = 6;

	typedef logic [MAX_QBIT_W-1:0] qbit_t;

	// cycles from a state read issue to its write-back issue
	// the ALU pipeline depth plus the memory read cycle
	localparam int ALU_LATENCY = 5;

	// run sequencing of one processing element
	typedef enum logic [2:0] {
		// waiting for a start
		SEQ_IDLE  = 3'd0,
		// gate descriptor fetch, three cycles
		SEQ_LOAD  = 3'd1,
		// coefficients out, walker launched
		SEQ_WALK  = 3'd2,
		// pairs in flight, wait for final write-back
		SEQ_DRAIN = 3'd3,
		// one cycle before the done pulse
		SEQ_DONE  = 3'd4
	} seq_state_t;

endpackage

`default_nettype wire
